/* rv32Core.f */
rv32Pkg.sv
controlUnit.sv
regFile.sv
alu.sv
loadStoreUnit.sv
rv32Core.sv
rv32Checker.sv
rv32CoreTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Builds the rv32Core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
logFile=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module rv32CoreTb \
        -f rv32Core.f -o simRv32Core; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simRv32Core > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "ERRORS FOUND" "$logFile"; then
    echo "Simulation reported failures"
    exit 1
fi
exit 0

/* rv32CoreTb.sv */
`timescale 1ns/1ns

module rv32CoreTb;

    localparam logic [31:0] ResetPc = 32'h0000_0000;
    localparam logic [31:0] Seed = 32'd72628;
    localparam int ProgLen = 600;
    localparam int ResetCycles = 4;
    localparam int CycleLimit = 4 * ProgLen + ResetCycles;
    // JAL x0, 0 parks the core once the program is done
    localparam logic [31:0] SelfLoop = 32'h0000_006f;
    localparam logic [6:0] OpcLui = 7'b0110111;
    localparam logic [6:0] OpcAuipc = 7'b0010111;
    localparam logic [6:0] OpcJalr = 7'b1100111;
    localparam logic [6:0] OpcLoad = 7'b0000011;
    localparam logic [6:0] OpcOpImm = 7'b0010011;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [31:0] instr;
    logic [31:0] dataRdata;
    logic [31:0] instrAddr;
    rv32Pkg::dataReqT dataReq;
    logic [31:0] writeMask;
    logic [31:0] instrMem [1024];
    logic [31:0] dataMem [256];
    logic [31:0] seed;
    logic [9:0]  pos;
    int cycleCount = 0;
    int errorCount;
    int checkCount;

    always #5 clk = ~clk;

    rv32Core #(.ResetPc(ResetPc)) rv32Core_i (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .dataRdata(dataRdata),
        .instrAddr(instrAddr),
        .dataReq  (dataReq)
    );

    rv32Checker #(.ResetPc(ResetPc)) rv32Checker_i (
        .clk       (clk),
        .rst       (rst),
        .instrAddr (instrAddr),
        .dataReq   (dataReq),
        .progMem   (instrMem),
        .dataMem   (dataMem),
        .errorCount(errorCount),
        .checkCount(checkCount)
    );

    // Both memories answer in the same cycle, data is word addressed
    assign instr = instrMem[instrAddr[11:2]];
    assign dataRdata = dataMem[dataReq.addr[9:2]];
    assign writeMask = {{8{dataReq.byteEn[3]}}, {8{dataReq.byteEn[2]}},
                        {8{dataReq.byteEn[1]}}, {8{dataReq.byteEn[0]}}};

    always @(posedge clk)
    begin
        if (dataReq.we)
        begin
            dataMem[dataReq.addr[9:2]] <= (dataMem[dataReq.addr[9:2]] & ~writeMask)
                                        | (dataReq.wdata & writeMask);
        end
    end

    function automatic logic [31:0] nextRand();
        logic [31:0] hi;
        seed = seed * 32'd1664525 + 32'd1013904223;
        hi = seed;
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {hi[31:16], seed[31:16]};
    endfunction

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic putInstr(input logic [31:0] word);
        instrMem[pos] = word;
        pos = pos + 10'd1;
    endtask

    // One random ALU, immediate, LUI or AUIPC instruction, never writing x7
    task automatic randomAlu();
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic        alt;
        f3 = 3'(nextRand() % 32'd8);
        rd = 5'(nextRand() % 32'd7);
        rs1 = 5'(nextRand() % 32'd8);
        rs2 = 5'(nextRand() % 32'd8);
        imm = 12'(nextRand());
        alt = (f3 == 3'd0 || f3 == 3'd5) && (nextRand() % 32'd2 == 32'd1);
        case (nextRand() % 32'd4)
            32'd0: putInstr(rType({1'b0, alt, 5'd0}, rs2, rs1, f3, rd));
            32'd1:
            begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm = {1'b0, alt, 5'd0, imm[4:0]};
                putInstr(iType(imm, rs1, f3, rd, OpcOpImm));
            end
            32'd2: putInstr(uType(20'(nextRand()), rd, OpcLui));
            default: putInstr(uType(20'(nextRand()), rd, OpcAuipc));
        endcase
    endtask

    // Base register x7 points into the data window at 0x10100
    task automatic setBase();
        putInstr(uType(20'h00010, 5'd7, OpcLui));
        putInstr(iType(12'h100, 5'd7, 3'd0, 5'd7, OpcOpImm));
    endtask

    // Jumps and branches skip only whole single-instruction fillers
    task automatic genProgram();
        logic [1:0]  skip;
        logic [12:0] off;
        logic [2:0]  f3;
        logic [4:0]  rd;
        int          addrOff;
        pos = ResetPc[11:2];
        // SW x0 at the reset address, so a store sits on the data port during reset
        putInstr(sType(12'd0, 5'd0, 5'd0, 3'b010));
        for (int r = 1; r < 7; r++)
        begin
            putInstr(uType(20'(nextRand()), 5'(r), OpcLui));
            putInstr(iType(12'(nextRand()), 5'(r), 3'd0, 5'(r), OpcOpImm));
        end
        setBase();
        while (pos < 10'(ProgLen - 16))
        begin
            skip = 2'(nextRand() % 32'd3);
            off = 13'(skip) * 13'd4 + 13'd4;
            rd = 5'(nextRand() % 32'd7);
            f3 = 3'(nextRand() % 32'd8);
            case (nextRand() % 32'd8)
                32'd3:
                begin
                    if (f3[2:1] == 2'b01)
                        f3[2] = 1'b1;
                    putInstr(bType(off, 5'(nextRand() % 32'd8), 5'(nextRand() % 32'd8), f3));
                    repeat (skip) randomAlu();
                end
                32'd4:
                begin
                    putInstr(jType(21'(off), rd));
                    repeat (skip) randomAlu();
                end
                32'd5:
                begin
                    // Odd offsets check that JALR clears bit 0
                    putInstr(uType(20'd0, 5'd6, OpcAuipc));
                    putInstr(iType(12'(off) + 12'd4 + 12'(nextRand() % 32'd2), 5'd6, 3'd0, rd,
                                   OpcJalr));
                    repeat (skip) randomAlu();
                end
                32'd6, 32'd7:
                begin
                    setBase();
                    addrOff = (int'(nextRand() % 32'd256) - 64) * 4;
                    case (nextRand() % 32'd5)
                        32'd0: f3 = 3'b000;
                        32'd1: f3 = 3'b001;
                        32'd2: f3 = 3'b010;
                        32'd3: f3 = 3'b100;
                        default: f3 = 3'b101;
                    endcase
                    if (f3[1:0] == 2'b00)
                        addrOff = addrOff + int'(nextRand() % 32'd4);
                    else if (f3[1:0] == 2'b01)
                        addrOff = addrOff + 2 * int'(nextRand() % 32'd2);
                    if (nextRand() % 32'd2 == 32'd0)
                        putInstr(iType(12'(addrOff), 5'd7, f3, rd, OpcLoad));
                    else
                        putInstr(sType(12'(addrOff), 5'(nextRand() % 32'd8), 5'd7,
                                       {1'b0, f3[1:0]}));
                end
                default: randomAlu();
            endcase
        end
        // Final register contents, x0 included, go out through SW
        setBase();
        for (int r = 0; r < 8; r++)
        begin
            putInstr(sType(12'(r * 4), 5'(r), 5'd7, 3'b010));
        end
    endtask

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit)
        begin
            $display("Timeout: the program did not reach its final loop in %0d cycles",
                     CycleLimit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial
    begin
        seed = Seed;
        foreach (dataMem[i])
            dataMem[i] <= nextRand();
        foreach (instrMem[i])
            instrMem[i] = SelfLoop;
        genProgram();
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        while (instrMem[instrAddr[11:2]] != SelfLoop)
            @(negedge clk);
        repeat (3) @(negedge clk);
        @(posedge clk);
        $display("Cycles checked: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* rv32Checker.sv */
`timescale 1ns/1ns

module rv32Checker #(
    parameter logic [31:0] ResetPc = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      instrAddr,
    input  rv32Pkg::dataReqT dataReq,
    input  logic [31:0]      progMem [1024],
    input  logic [31:0]      dataMem [256],
    output int               errorCount,
    output int               checkCount
);

    // Architectural effect of one instruction
    typedef struct packed {
        logic [31:0] nextPc;
        logic        regWe;
        logic [4:0]  rd;
        logic [31:0] rdVal;
        logic        storeWe;
        logic [31:0] storeAddr;
        logic [3:0]  storeEn;
        logic [31:0] storeData;
    } stepT;

    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [256];
    logic [31:0] modelPc;
    logic [31:0] laneMask;
    stepT        expected;

    initial
    begin
        errorCount = 0;
        checkCount = 0;
    end

    function automatic logic [31:0] byteMask(input logic [3:0] en);
        return {{8{en[3]}}, {8{en[2]}}, {8{en[1]}}, {8{en[0]}}};
    endfunction

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'd0, $signed(a) < $signed(b)};
            3'b011: return {31'd0, a < b};
            3'b100: return a ^ b;
            3'b101: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic stepT refStep(input logic [31:0] pc, input logic [31:0] ins);
        stepT        s;
        logic [2:0]  f3;
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] iImm;
        logic [31:0] sImm;
        logic [31:0] addr;
        logic [31:0] lane;
        logic        cond;
        s = '0;
        f3 = ins[14:12];
        rs1v = modelRegs[ins[19:15]];
        rs2v = modelRegs[ins[24:20]];
        iImm = {{20{ins[31]}}, ins[31:20]};
        sImm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        s.nextPc = pc + 32'd4;
        s.rd = ins[11:7];
        case (ins[6:0])
            7'b0110111:
            begin
                s.regWe = 1'b1;
                s.rdVal = {ins[31:12], 12'h000};
            end
            7'b0010111:
            begin
                s.regWe = 1'b1;
                s.rdVal = pc + {ins[31:12], 12'h000};
            end
            7'b1101111:
            begin
                s.regWe = 1'b1;
                s.rdVal = pc + 32'd4;
                s.nextPc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b1100111:
            begin
                s.regWe = 1'b1;
                s.rdVal = pc + 32'd4;
                s.nextPc = (rs1v + iImm) & ~32'd1;
            end
            7'b1100011:
            begin
                case (f3)
                    3'b000: cond = rs1v == rs2v;
                    3'b001: cond = rs1v != rs2v;
                    3'b100: cond = $signed(rs1v) < $signed(rs2v);
                    3'b101: cond = $signed(rs1v) >= $signed(rs2v);
                    3'b110: cond = rs1v < rs2v;
                    3'b111: cond = rs1v >= rs2v;
                    default: cond = 1'b0;
                endcase
                if (cond)
                    s.nextPc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'b0000011:
            begin
                addr = rs1v + iImm;
                lane = modelMem[addr[9:2]] >> {addr[1:0], 3'b000};
                s.regWe = 1'b1;
                case (f3)
                    3'b000: s.rdVal = {{24{lane[7]}}, lane[7:0]};
                    3'b001: s.rdVal = {{16{lane[15]}}, lane[15:0]};
                    3'b100: s.rdVal = {24'd0, lane[7:0]};
                    3'b101: s.rdVal = {16'd0, lane[15:0]};
                    default: s.rdVal = lane;
                endcase
            end
            7'b0100011:
            begin
                addr = rs1v + sImm;
                s.storeWe = 1'b1;
                s.storeAddr = addr;
                case (f3)
                    3'b000:
                    begin
                        s.storeEn = 4'b0001 << addr[1:0];
                        s.storeData = {4{rs2v[7:0]}};
                    end
                    3'b001:
                    begin
                        s.storeEn = 4'b0011 << addr[1:0];
                        s.storeData = {2{rs2v[15:0]}};
                    end
                    default:
                    begin
                        s.storeEn = 4'b1111;
                        s.storeData = rs2v;
                    end
                endcase
            end
            7'b0010011:
            begin
                s.regWe = 1'b1;
                s.rdVal = aluRef(f3, f3 == 3'b101 && ins[30], rs1v, iImm);
            end
            7'b0110011:
            begin
                s.regWe = 1'b1;
                s.rdVal = aluRef(f3, ins[30], rs1v, rs2v);
            end
            // FENCE, SYSTEM and anything unknown only advance the PC
            default: s.regWe = 1'b0;
        endcase
        return s;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
        errorCount = errorCount + 1;
    endtask

    // Outputs are compared at the falling edge where they have settled
    always @(negedge clk)
    begin
        if (rst)
        begin
            modelPc = ResetPc;
            foreach (modelRegs[i])
                modelRegs[i] = 32'd0;
            foreach (modelMem[i])
                modelMem[i] = dataMem[i];
            if (instrAddr !== ResetPc)
                reportMismatch("instrAddr", instrAddr, ResetPc);
            if (dataReq.we !== 1'b0)
            begin
                $display("Store request issued at %0t while reset is asserted", $time);
                errorCount = errorCount + 1;
            end
        end
        else
        begin
            checkCount = checkCount + 1;
            expected = refStep(modelPc, progMem[modelPc[11:2]]);
            laneMask = byteMask(expected.storeEn);
            if (instrAddr !== modelPc)
                reportMismatch("instrAddr", instrAddr, modelPc);
            if (dataReq.we !== expected.storeWe)
                reportMismatch("dataReq.we", 32'(dataReq.we), 32'(expected.storeWe));
            else if (expected.storeWe)
            begin
                if (dataReq.addr !== expected.storeAddr)
                    reportMismatch("dataReq.addr", dataReq.addr, expected.storeAddr);
                if (dataReq.byteEn !== expected.storeEn)
                    reportMismatch("dataReq.byteEn", 32'(dataReq.byteEn), 32'(expected.storeEn));
                if ((dataReq.wdata & laneMask) !== (expected.storeData & laneMask))
                    reportMismatch("dataReq.wdata", dataReq.wdata & laneMask,
                                   expected.storeData & laneMask);
            end
            if (expected.storeWe)
            begin
                modelMem[expected.storeAddr[9:2]] = (modelMem[expected.storeAddr[9:2]] & ~laneMask)
                                                  | (expected.storeData & laneMask);
            end
            if (expected.regWe && expected.rd != 5'd0)
                modelRegs[expected.rd] = expected.rdVal;
            modelPc = expected.nextPc;
        end
    end

endmodule

/* rv32Core.sv */
`timescale 1ns/1ns

module rv32Core #(
    parameter logic [31:0] ResetPc = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      instr,
    input  logic [31:0]      dataRdata,
    output logic [31:0]      instrAddr,
    output rv32Pkg::dataReqT dataReq
);

    rv32Pkg::ctrlT    ctrl;
    rv32Pkg::dataReqT lsuReq;
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] pcPlus4;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [31:0] loadData;
    logic [31:0] wbData;
    logic        taken;

    controlUnit controlUnit_i (.instr(instr), .ctrl(ctrl));

    regFile regFile_i (
        .clk(clk),
        .ra1(ctrl.rfRa1),
        .ra2(ctrl.rfRa2),
        .wa (ctrl.rfWa),
        .we (ctrl.rfWe && !rst),
        .wd (wbData),
        .rd1(rd1),
        .rd2(rd2)
    );

    assign aluA = ctrl.aluSrcPc ? pc : rd1;
    assign aluB = ctrl.aluSrcImm ? ctrl.imm : rd2;

    alu alu_i (
        .a     (aluA),
        .b     (aluB),
        .op    (ctrl.aluOp),
        .funct3(ctrl.funct3),
        .result(aluResult),
        .taken (taken)
    );

    loadStoreUnit loadStoreUnit_i (
        .ctrl     (ctrl),
        .addr     (aluResult),
        .storeVal (rd2),
        .dataRdata(dataRdata),
        .dataReq  (lsuReq),
        .loadData (loadData)
    );

    // No store may reach memory while the core is held in reset
    always_comb
    begin
        dataReq = lsuReq;
        dataReq.we = lsuReq.we && !rst;
    end

    always_comb
    begin
        case (ctrl.wbSel)
            rv32Pkg::wbMem:     wbData = loadData;
            rv32Pkg::wbPcPlus4: wbData = pcPlus4;
            default:            wbData = aluResult;
        endcase
    end

    assign pcPlus4 = pc + 32'd4;

    always_comb
    begin
        if (ctrl.isJalr)
            nextPc = {aluResult[31:1], 1'b0};
        else if (ctrl.isJal || (ctrl.isBranch && taken))
            nextPc = pc + ctrl.imm;
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= ResetPc;
        else
            pc <= nextPc;
    end

    assign instrAddr = pc;

    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("rv32Core: PC not word aligned");

endmodule

/* loadStoreUnit.sv */
`timescale 1ns/1ns

module loadStoreUnit (
    input  rv32Pkg::ctrlT    ctrl,
    input  logic [31:0]      addr,
    input  logic [31:0]      storeVal,
    input  logic [31:0]      dataRdata,
    output rv32Pkg::dataReqT dataReq,
    output logic [31:0]      loadData
);

    logic [4:0]  laneShift;
    logic [3:0]  sizeMask;
    logic [31:0] lane;

    // Bit offset of the addressed byte within the word
    assign laneShift = {addr[1:0], 3'b000};

    always_comb
    begin
        case (ctrl.funct3[1:0])
            2'b00:   sizeMask = 4'b0001;
            2'b01:   sizeMask = 4'b0011;
            default: sizeMask = 4'b1111;
        endcase
    end

    always_comb
    begin
        dataReq.addr = addr;
        dataReq.wdata = storeVal << laneShift;
        dataReq.we = ctrl.memWrite;
        if (ctrl.memRead || ctrl.memWrite)
        begin
            dataReq.byteEn = sizeMask << addr[1:0];
        end
        else
        begin
            dataReq.byteEn = 4'b0000;
        end
    end

    // Move the addressed lane down to bit 0 before extending
    assign lane = dataRdata >> laneShift;

    always_comb
    begin
        case (ctrl.funct3)
            3'b000:  loadData = {{24{lane[7]}}, lane[7:0]};
            3'b001:  loadData = {{16{lane[15]}}, lane[15:0]};
            3'b100:  loadData = {24'd0, lane[7:0]};
            3'b101:  loadData = {16'd0, lane[15:0]};
            default: loadData = lane;
        endcase
    end

endmodule

/* alu.sv */
`timescale 1ns/1ns

module alu (
    input  logic [31:0]    a,
    input  logic [31:0]    b,
    input  rv32Pkg::aluOpE op,
    input  logic [2:0]     funct3,
    output logic [31:0]    result,
    output logic           taken
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;
    logic       equal;

    assign shamt = b[4:0];
    assign ltSigned = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;
    assign equal = (a == b);

    always_comb
    begin
        case (op)
            rv32Pkg::aluAdd:   result = a + b;
            rv32Pkg::aluSub:   result = a - b;
            rv32Pkg::aluSll:   result = a << shamt;
            rv32Pkg::aluSlt:   result = {31'd0, ltSigned};
            rv32Pkg::aluSltu:  result = {31'd0, ltUnsigned};
            rv32Pkg::aluXor:   result = a ^ b;
            rv32Pkg::aluSrl:   result = a >> shamt;
            rv32Pkg::aluSra:   result = 32'($signed(a) >>> shamt);
            rv32Pkg::aluOr:    result = a | b;
            rv32Pkg::aluAnd:   result = a & b;
            rv32Pkg::aluPassB: result = b;
            default:           result = 32'd0;
        endcase
    end

    // Branch condition, meaningful only when the decoder flags a branch
    always_comb
    begin
        case (funct3)
            3'b000:  taken = equal;
            3'b001:  taken = !equal;
            3'b100:  taken = ltSigned;
            3'b101:  taken = !ltSigned;
            3'b110:  taken = ltUnsigned;
            3'b111:  taken = !ltUnsigned;
            default: taken = 1'b0;
        endcase
    end

endmodule

/* regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic        clk,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    // x0 is hardwired to zero
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

    always_ff @(posedge clk)
    begin
        if (we && (wa != 5'd0))
        begin
            regs[wa] <= wd;
        end
    end

    // A written register shows up on either read port one cycle later
    assert property (@(posedge clk)
        $past(we) && ($past(wa) != 5'd0) && (ra1 == $past(wa)) |-> (rd1 == $past(wd)))
        else $error("regFile: read port 1 misses the last written value");

    assert property (@(posedge clk)
        $past(we) && ($past(wa) != 5'd0) && (ra2 == $past(wa)) |-> (rd2 == $past(wd)))
        else $error("regFile: read port 2 misses the last written value");

endmodule

/* controlUnit.sv */
`timescale 1ns/1ns

module controlUnit (
    input  logic [31:0]   instr,
    output rv32Pkg::ctrlT ctrl
);

    rv32Pkg::opcodeE opcode;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    // ALU operation for the OP and OP-IMM groups
    function automatic rv32Pkg::aluOpE arithOp(input logic [2:0] f3, input logic alt,
                                               input logic isReg);
        rv32Pkg::aluOpE sel;
        case (f3)
            3'b000: sel = (isReg && alt) ? rv32Pkg::aluSub : rv32Pkg::aluAdd;
            3'b001: sel = rv32Pkg::aluSll;
            3'b010: sel = rv32Pkg::aluSlt;
            3'b011: sel = rv32Pkg::aluSltu;
            3'b100: sel = rv32Pkg::aluXor;
            3'b101: sel = alt ? rv32Pkg::aluSra : rv32Pkg::aluSrl;
            3'b110: sel = rv32Pkg::aluOr;
            default: sel = rv32Pkg::aluAnd;
        endcase
        return sel;
    endfunction

    // Sign-extended immediates for every format
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'h000};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        opcode = rv32Pkg::opcodeE'(instr[6:0]);
        ctrl = '0;
        case (opcode)
            rv32Pkg::opcLui:
            begin
                ctrl.rfWa = instr[11:7];
                ctrl.rfWe = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = rv32Pkg::aluPassB;
                ctrl.imm = immU;
            end
            rv32Pkg::opcAuipc:
            begin
                ctrl.rfWa = instr[11:7];
                ctrl.rfWe = 1'b1;
                ctrl.aluSrcPc = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm = immU;
            end
            rv32Pkg::opcJal:
            begin
                ctrl.rfWa = instr[11:7];
                ctrl.rfWe = 1'b1;
                ctrl.isJal = 1'b1;
                ctrl.wbSel = rv32Pkg::wbPcPlus4;
                ctrl.imm = immJ;
            end
            rv32Pkg::opcJalr:
            begin
                // Target is computed by the ALU as rs1 + imm
                ctrl.rfRa1 = instr[19:15];
                ctrl.rfWa = instr[11:7];
                ctrl.rfWe = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.isJalr = 1'b1;
                ctrl.wbSel = rv32Pkg::wbPcPlus4;
                ctrl.imm = immI;
            end
            rv32Pkg::opcBranch:
            begin
                ctrl.rfRa1 = instr[19:15];
                ctrl.rfRa2 = instr[24:20];
                ctrl.isBranch = 1'b1;
                ctrl.funct3 = instr[14:12];
                ctrl.aluOp = rv32Pkg::aluSub;
                ctrl.imm = immB;
            end
            rv32Pkg::opcLoad:
            begin
                ctrl.rfRa1 = instr[19:15];
                ctrl.rfWa = instr[11:7];
                ctrl.rfWe = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.funct3 = instr[14:12];
                ctrl.wbSel = rv32Pkg::wbMem;
                ctrl.imm = immI;
            end
            rv32Pkg::opcStore:
            begin
                ctrl.rfRa1 = instr[19:15];
                ctrl.rfRa2 = instr[24:20];
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.funct3 = instr[14:12];
                ctrl.imm = immS;
            end
            rv32Pkg::opcOpImm:
            begin
                ctrl.rfRa1 = instr[19:15];
                ctrl.rfWa = instr[11:7];
                ctrl.rfWe = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.funct3 = instr[14:12];
                ctrl.aluOp = arithOp(instr[14:12], instr[30], 1'b0);
                ctrl.imm = immI;
            end
            rv32Pkg::opcOp:
            begin
                ctrl.rfRa1 = instr[19:15];
                ctrl.rfRa2 = instr[24:20];
                ctrl.rfWa = instr[11:7];
                ctrl.rfWe = 1'b1;
                ctrl.funct3 = instr[14:12];
                ctrl.aluOp = arithOp(instr[14:12], instr[30], 1'b1);
            end
            // FENCE, SYSTEM and unknown encodings fall through as a no-op
            default: ctrl = '0;
        endcase
    end

endmodule

/* rv32Pkg.sv */
package rv32Pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opcLui    = 7'b0110111,
        opcAuipc  = 7'b0010111,
        opcJal    = 7'b1101111,
        opcJalr   = 7'b1100111,
        opcBranch = 7'b1100011,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcOpImm  = 7'b0010011,
        opcOp     = 7'b0110011,
        opcOther  = 7'b0000000
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOpE;

    // Register write-back source
    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbPcPlus4
    } wbSelE;

    typedef struct packed {
        logic [4:0]  rfRa1;
        logic [4:0]  rfRa2;
        logic [4:0]  rfWa;
        logic        rfWe;
        logic        aluSrcImm;
        logic        aluSrcPc;
        logic        memRead;
        logic        memWrite;
        logic        isBranch;
        logic        isJal;
        logic        isJalr;
        logic [2:0]  funct3;
        aluOpE       aluOp;
        wbSelE       wbSel;
        logic [31:0] imm;
    } ctrlT;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byteEn;
        logic        we;
    } dataReqT;

endpackage
